/* files.f */
common/lcd_i2c_pkg.sv
verilog/txn_fifo.sv
lcd_sequencer/lcd_sequencer.sv
i2c_master/i2c_master.sv
verilog/lcd_i2c_top.sv
tb/i2c_target_model.sv
tb/tb_lcd_i2c.sv

/* Makefile */
RTL = common/lcd_i2c_pkg.sv verilog/txn_fifo.sv lcd_sequencer/lcd_sequencer.sv \
      i2c_master/i2c_master.sv verilog/lcd_i2c_top.sv

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f files.f --top-module tb_lcd_i2c -o Vtb_lcd_i2c
	./obj_dir/Vtb_lcd_i2c

lint:
	verilator --lint-only -Wall $(RTL) --top-module lcd_i2c_top

clean:
	rm -rf obj_dir

/* tb/tb_lcd_i2c.sv */
// LCD over I2C testbench
module tb_lcd_i2c;

    logic       clk;
    logic       reset_n;
    logic       sda_in;
    logic       scl;
    logic       sda_oe;
    logic       found;
    logic [6:0] found_addr;
    logic       no_device;
    logic       done;
    logic       model_pull;
    logic [6:0] target_addr;
    logic       rpt_valid;
    logic [6:0] rpt_addr;
    logic [7:0] rpt_data;
    logic       rpt_ack;
    logic [6:0] seen_addr [$];
    logic [7:0] seen_data [$];
    logic       seen_ack [$];

    assign sda_in = ~(sda_oe | model_pull);  // Open drain line

    lcd_i2c_top #(
        .clk_div         (4),
        .power_up_cycles (20),
        .probe_gap_cycles(10),
        .cmd_gap_cycles  (30),
        .fifo_depth      (4)
    ) dut (
        .clk       (clk),
        .reset_n   (reset_n),
        .sda_in    (sda_in),
        .scl       (scl),
        .sda_oe    (sda_oe),
        .found     (found),
        .found_addr(found_addr),
        .no_device (no_device),
        .done      (done)
    );

    i2c_target_model target (
        .clk        (clk),
        .reset_n    (reset_n),
        .scl        (scl),
        .sda        (sda_in),
        .target_addr(target_addr),
        .pull       (model_pull),
        .rpt_valid  (rpt_valid),
        .rpt_addr   (rpt_addr),
        .rpt_data   (rpt_data),
        .rpt_ack    (rpt_ack)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (rpt_valid) begin
            seen_addr.push_back(rpt_addr);
            seen_data.push_back(rpt_data);
            seen_ack.push_back(rpt_ack);
        end
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
        else fail_run($sformatf("MISMATCH %s got %0h expected %0h", name, got, exp));
    endtask

    function automatic logic flag_high(input string what);
        if (what == "found") return found;
        if (what == "done") return done;
        return no_device;
    endfunction

    task automatic wait_for_flag(input string what, input int limit);
        int cycles;
        cycles = 0;
        while (!flag_high(what)) begin
            if (cycles == limit) fail_run({"Timed out waiting for ", what, " to rise"});
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic check_idle_outputs();
        check_hex("found", 32'(found), 0);
        check_hex("no_device", 32'(no_device), 0);
        check_hex("done", 32'(done), 0);
        check_hex("scl", 32'(scl), 1);
        check_hex("sda_oe", 32'(sda_oe), 0);
    endtask

    task automatic apply_reset(input logic [6:0] addr);
        @(posedge clk);
        #1;
        reset_n = 1'b0;
        target_addr = addr;
        seen_addr.delete();
        seen_data.delete();
        seen_ack.delete();
        repeat (4) @(posedge clk);
        #1;
        check_idle_outputs();
        reset_n = 1'b1;
        @(posedge clk);
        #1;
        check_idle_outputs();
    endtask

    // Expected {rs, byte} for LCD byte number g after the scan
    function automatic logic [8:0] lcd_expected(input int g);
        int c;
        if (g < lcd_i2c_pkg::init_count) return {1'b0, lcd_i2c_pkg::init_cmds[g]};
        c = g - lcd_i2c_pkg::init_count;
        if (c == lcd_i2c_pkg::line_len) return {1'b0, lcd_i2c_pkg::line2_cmd};
        if (c > lcd_i2c_pkg::line_len) c = c - 1;
        if (c == 24) return {1'b1, 8'h32};  // Address 27 in hex
        if (c == 25) return {1'b1, 8'h37};
        return {1'b1, lcd_i2c_pkg::message[8 * (2 * lcd_i2c_pkg::line_len - 1 - c) +: 8]};
    endfunction

    task automatic check_lcd_stream();
        logic [8:0]                  exp;
        lcd_i2c_pkg::expander_byte_u got;
        int                          k;
        check_hex("transaction count", seen_addr.size(),
            2 + 4 * (lcd_i2c_pkg::init_count + 2 * lcd_i2c_pkg::line_len + 1));
        for (int i = 2; i < seen_addr.size(); i++) begin
            k = (i - 2) % 4;
            exp = lcd_expected((i - 2) / 4);
            got.raw = seen_data[i];
            check_hex($sformatf("rpt_addr[%0d]", i), 32'(seen_addr[i]), 32'h27);
            check_hex($sformatf("rpt_ack[%0d]", i), 32'(seen_ack[i]), 1);
            check_hex($sformatf("backlight[%0d]", i), 32'(got.lcd.backlight), 1);
            check_hex($sformatf("rw[%0d]", i), 32'(got.lcd.rw), 0);
            check_hex($sformatf("en[%0d]", i), 32'(got.lcd.en), 32'(k % 2 == 0));
            check_hex($sformatf("rs[%0d]", i), 32'(got.lcd.rs), 32'(exp[8]));
            check_hex($sformatf("nibble[%0d]", i), 32'(got.lcd.nibble),
                32'((k < 2) ? exp[7:4] : exp[3:0]));
        end
    endtask

    task automatic check_probe(input int i, input logic ack);
        check_hex($sformatf("probe rpt_addr[%0d]", i), 32'(seen_addr[i]),
            32'(lcd_i2c_pkg::probe_addrs[i]));
        check_hex($sformatf("probe rpt_data[%0d]", i), 32'(seen_data[i]), 0);
        check_hex($sformatf("probe rpt_ack[%0d]", i), 32'(seen_ack[i]), 32'(ack));
    endtask

    initial begin
        reset_n = 1'b0;
        target_addr = 7'h27;

        // Expander at 27
        apply_reset(7'h27);
        wait_for_flag("found", 5000);
        check_hex("probe count", seen_addr.size(), 2);
        check_probe(0, 1'b0);
        check_probe(1, 1'b1);
        check_hex("found_addr", 32'(found_addr), 32'h27);
        wait_for_flag("done", 200000);
        check_lcd_stream();
        check_hex("no_device", 32'(no_device), 0);

        // Nothing answers
        apply_reset(7'h50);
        wait_for_flag("no_device", 20000);
        repeat (2000) @(posedge clk);
        #1;
        check_hex("probe count", seen_addr.size(), lcd_i2c_pkg::probe_count);
        for (int i = 0; i < lcd_i2c_pkg::probe_count; i++) check_probe(i, 1'b0);
        check_hex("found", 32'(found), 0);
        check_hex("done", 32'(done), 0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* tb/i2c_target_model.sv */
// I2C port expander model
module i2c_target_model (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       scl,
    input  logic       sda,
    input  logic [6:0] target_addr,
    output logic       pull,
    output logic       rpt_valid,
    output logic [6:0] rpt_addr,
    output logic [7:0] rpt_data,
    output logic       rpt_ack
);

    logic       scl_q;
    logic       sda_q;
    logic       active;
    logic [3:0] bit_cnt;   // 8 marks the ack slot
    logic [1:0] byte_cnt;
    logic [7:0] shift;
    logic [7:0] addr_byte;

    assign rpt_addr = addr_byte[7:1];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scl_q <= 1'b1;
            sda_q <= 1'b1;
            active <= 1'b0;
            bit_cnt <= '0;
            byte_cnt <= '0;
            shift <= '0;
            addr_byte <= '0;
            pull <= 1'b0;
            rpt_valid <= 1'b0;
            rpt_data <= '0;
            rpt_ack <= 1'b0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            rpt_valid <= 1'b0;
            if (scl && scl_q && sda_q && !sda) begin  // Start
                active <= 1'b1;
                bit_cnt <= '0;
                byte_cnt <= '0;
                pull <= 1'b0;
                rpt_ack <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin  // Stop
                active <= 1'b0;
                rpt_valid <= active && (byte_cnt == 2'd2);
            end else if (active && scl && !scl_q) begin
                if (bit_cnt == 4'd8) begin
                    bit_cnt <= '0;
                    byte_cnt <= byte_cnt + 1'b1;
                end else begin
                    shift <= {shift[6:0], sda};
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 4'd7 && byte_cnt == 2'd0) addr_byte <= {shift[6:0], sda};
                    if (bit_cnt == 4'd7 && byte_cnt == 2'd1) rpt_data <= {shift[6:0], sda};
                end
            end else if (active && !scl && scl_q) begin
                // Hold SDA low through the address ack slot
                if (bit_cnt == 4'd8 && byte_cnt == 2'd0 && addr_byte[7:1] == target_addr) begin
                    pull <= 1'b1;
                    rpt_ack <= 1'b1;
                end else begin
                    pull <= 1'b0;
                end
            end
        end
    end

endmodule

/* verilog/lcd_i2c_top.sv */
// LCD message controller top
module lcd_i2c_top #(
    parameter int clk_div          = 250,         // 100 kHz SCL from 100 MHz
    parameter int power_up_cycles  = 50_000_000,
    parameter int probe_gap_cycles = 10_000_000,
    parameter int cmd_gap_cycles   = 500_000,
    parameter int fifo_depth       = 4
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               sda_in,
    output logic                               scl,
    output logic                               sda_oe,
    output logic                               found,
    output logic [lcd_i2c_pkg::i2c_addr_w-1:0] found_addr,
    output logic                               no_device,
    output logic                               done
);

    logic                          push;
    logic                          pop;
    logic                          full;
    logic                          empty;
    logic                          txn_done;
    logic                          ack_error;
    logic [lcd_i2c_pkg::txn_w-1:0] push_data;
    logic [lcd_i2c_pkg::txn_w-1:0] pop_data;

    lcd_sequencer #(
        .power_up_cycles (power_up_cycles),
        .probe_gap_cycles(probe_gap_cycles),
        .cmd_gap_cycles  (cmd_gap_cycles)
    ) u_sequencer (
        .clk       (clk),
        .reset_n   (reset_n),
        .full      (full),
        .txn_done  (txn_done),
        .ack_error (ack_error),
        .push      (push),
        .push_data (push_data),
        .found     (found),
        .found_addr(found_addr),
        .no_device (no_device),
        .done      (done)
    );

    txn_fifo #(
        .fifo_depth(fifo_depth)
    ) u_fifo (
        .clk      (clk),
        .reset_n  (reset_n),
        .push     (push),
        .push_data(push_data),
        .pop      (pop),
        .pop_data (pop_data),
        .full     (full),
        .empty    (empty)
    );

    i2c_master #(
        .clk_div(clk_div)
    ) u_master (
        .clk      (clk),
        .reset_n  (reset_n),
        .empty    (empty),
        .pop_data (pop_data),
        .sda_in   (sda_in),
        .pop      (pop),
        .scl      (scl),
        .sda_oe   (sda_oe),
        .txn_done (txn_done),
        .ack_error(ack_error)
    );

endmodule

/* i2c_master/i2c_master.sv */
// Single byte I2C write master
module i2c_master #(
    parameter int clk_div = 250
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          empty,
    input  logic [lcd_i2c_pkg::txn_w-1:0] pop_data,
    input  logic                          sda_in,
    output logic                          pop,
    output logic                          scl,
    output logic                          sda_oe,
    output logic                          txn_done,
    output logic                          ack_error
);

    localparam int div_w = (clk_div > 1) ? $clog2(clk_div) : 1;

    typedef enum logic [2:0] {
        st_idle, st_start, st_addr, st_ack1, st_data, st_ack2, st_stop
    } state_t;

    state_t                      state;
    logic [div_w-1:0]            div_cnt;
    logic [1:0]                  quarter;
    logic                        quarter_end;
    logic                        tick;        // End of a four-quarter bit slot
    logic [2:0]                  bit_cnt;
    logic [7:0]                  shift_q;
    lcd_i2c_pkg::expander_byte_u data_q;
    logic [1:0]                  sda_sync;

    assign quarter_end = (div_cnt == div_w'(clk_div - 1));
    assign tick = quarter_end && (quarter == 2'd3);
    assign pop = tick && (state == st_idle) && !empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            quarter <= '0;
            sda_sync <= 2'b11;
        end else begin
            div_cnt <= quarter_end ? '0 : div_cnt + 1'b1;
            if (quarter_end) quarter <= quarter + 1'b1;
            sda_sync <= {sda_sync[0], sda_in};
        end
    end

    // Address with write bit, then data, MSB first
    always_ff @(posedge clk) begin
        if (pop) begin
            shift_q <= {pop_data[lcd_i2c_pkg::txn_w-1 -: lcd_i2c_pkg::i2c_addr_w], 1'b0};
            data_q.raw <= pop_data[7:0];
        end else if (tick && state == st_ack1) begin
            shift_q <= data_q.raw;
        end else if (tick && (state == st_addr || state == st_data)) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= st_idle;
            bit_cnt <= '0;
            ack_error <= 1'b0;
            txn_done <= 1'b0;
        end else begin
            txn_done <= tick && (state == st_stop);
            if (tick) begin
                case (state)
                    st_idle:  if (!empty) state <= st_start;
                    st_start: begin
                        bit_cnt <= '0;
                        state <= st_addr;
                    end
                    st_addr, st_data: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= (state == st_addr) ? st_ack1 : st_ack2;
                    end
                    st_ack1: begin
                        ack_error <= sda_sync[1];  // High means no ack
                        state <= st_data;
                    end
                    st_ack2: state <= st_stop;
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // SCL low in quarters 0-1, SDA changes in quarter 1
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scl <= 1'b1;
            sda_oe <= 1'b0;
        end else begin
            case (state)
                st_start: begin
                    scl <= 1'b1;
                    if (quarter != 2'd0) sda_oe <= 1'b1;
                end
                st_addr, st_data: begin
                    scl <= quarter[1];
                    if (quarter == 2'd1) sda_oe <= ~shift_q[7];
                end
                st_ack1, st_ack2: begin
                    scl <= quarter[1];
                    if (quarter == 2'd1) sda_oe <= 1'b0;
                end
                st_stop: begin
                    scl <= quarter[1];
                    if (quarter == 2'd1) sda_oe <= 1'b1;
                    if (quarter == 2'd3) sda_oe <= 1'b0;  // SDA rises with SCL high
                end
                default: begin
                    scl <= 1'b1;
                    sda_oe <= 1'b0;
                end
            endcase
        end
    end

endmodule

/* lcd_sequencer/lcd_sequencer.sv */
// LCD scan, init and message sequencer
module lcd_sequencer #(
    parameter int power_up_cycles  = 50_000_000,
    parameter int probe_gap_cycles = 10_000_000,
    parameter int cmd_gap_cycles   = 500_000
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               full,
    input  logic                               txn_done,
    input  logic                               ack_error,
    output logic                               push,
    output logic [lcd_i2c_pkg::txn_w-1:0]      push_data,
    output logic                               found,
    output logic [lcd_i2c_pkg::i2c_addr_w-1:0] found_addr,
    output logic                               no_device,
    output logic                               done
);

    localparam int wait_max = (power_up_cycles > probe_gap_cycles)
        ? ((power_up_cycles > cmd_gap_cycles) ? power_up_cycles : cmd_gap_cycles)
        : ((probe_gap_cycles > cmd_gap_cycles) ? probe_gap_cycles : cmd_gap_cycles);
    localparam int wait_w = $clog2(wait_max + 2);
    localparam int probe_w = $clog2(lcd_i2c_pkg::probe_count);
    localparam int cmd_w = $clog2(lcd_i2c_pkg::init_count);
    localparam int char_w = $clog2(2 * lcd_i2c_pkg::line_len);
    localparam int write_bytes = 2 * lcd_i2c_pkg::line_len + 1;  // Line two command included
    localparam int byte_w = $clog2(write_bytes);
    localparam int lcd_txns = 4 * (lcd_i2c_pkg::init_count + write_bytes);
    localparam int txn_cnt_w = $clog2(lcd_txns + 1);
    localparam logic [char_w-1:0] addr_char_hi = char_w'(24);
    localparam logic [char_w-1:0] addr_char_lo = char_w'(25);

    typedef enum logic [2:0] {ph_power, ph_scan, ph_init, ph_write, ph_finish} phase_t;
    typedef enum logic [1:0] {sp_send, sp_wait, sp_gap} step_t;

    phase_t                      phase;
    step_t                       step;
    logic [wait_w-1:0]           wait_cnt;
    logic [wait_w-1:0]           wait_target;
    logic                        wait_end;
    logic [probe_w-1:0]          probe_idx;
    logic [cmd_w-1:0]            cmd_idx;
    logic [byte_w-1:0]           byte_idx;
    logic [char_w-1:0]           char_idx;
    logic [1:0]                  nib_step;   // Hi en, hi, lo en, lo
    logic [txn_cnt_w-1:0]        lcd_txn_cnt;
    logic [7:0]                  lcd_byte;
    logic                        lcd_rs;
    logic [lcd_i2c_pkg::i2c_addr_w-1:0] cur_addr;
    lcd_i2c_pkg::expander_byte_u exp_byte;

    always_comb begin
        case (phase)
            ph_power: wait_target = wait_w'(power_up_cycles);
            ph_scan:  wait_target = wait_w'(probe_gap_cycles);
            default:  wait_target = wait_w'(cmd_gap_cycles);
        endcase
    end

    assign wait_end = (wait_cnt == wait_target);

    // Pick the LCD byte for the current slot
    always_comb begin
        char_idx = (byte_idx > byte_w'(lcd_i2c_pkg::line_len))
            ? char_w'(byte_idx - 1'b1) : char_w'(byte_idx);
        lcd_rs = 1'b1;
        if (phase == ph_init) begin
            lcd_byte = lcd_i2c_pkg::init_cmds[cmd_idx];
            lcd_rs = 1'b0;
        end else if (byte_idx == byte_w'(lcd_i2c_pkg::line_len)) begin
            lcd_byte = lcd_i2c_pkg::line2_cmd;
            lcd_rs = 1'b0;
        end else if (char_idx == addr_char_hi) begin
            lcd_byte = lcd_i2c_pkg::hex_ascii({1'b0, found_addr[6:4]});
        end else if (char_idx == addr_char_lo) begin
            lcd_byte = lcd_i2c_pkg::hex_ascii(found_addr[3:0]);
        end else begin
            lcd_byte = lcd_i2c_pkg::message[
                8 * (2 * lcd_i2c_pkg::line_len - 1 - int'(char_idx)) +: 8];
        end
    end

    always_comb begin
        exp_byte.lcd.nibble = nib_step[1] ? lcd_byte[3:0] : lcd_byte[7:4];
        exp_byte.lcd.backlight = 1'b1;
        exp_byte.lcd.en = ~nib_step[0];
        exp_byte.lcd.rw = 1'b0;
        exp_byte.lcd.rs = lcd_rs;
    end

    assign cur_addr = found ? found_addr : lcd_i2c_pkg::probe_addrs[probe_idx];
    assign push = (step == sp_send) && !full
        && (phase == ph_scan || phase == ph_init || phase == ph_write);
    assign push_data = {cur_addr, (phase == ph_scan) ? 8'h00 : exp_byte.raw};  // Probe is a zero

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            phase <= ph_power;
            step <= sp_send;
            wait_cnt <= '0;
            probe_idx <= '0;
            cmd_idx <= '0;
            byte_idx <= '0;
            nib_step <= '0;
            lcd_txn_cnt <= '0;
            found <= 1'b0;
            found_addr <= '0;
            no_device <= 1'b0;
            done <= 1'b0;
        end else begin
            if (txn_done && found) begin
                lcd_txn_cnt <= lcd_txn_cnt + 1'b1;
            end
            case (phase)
                ph_power: begin
                    wait_cnt <= wait_end ? '0 : wait_cnt + 1'b1;
                    if (wait_end) phase <= ph_scan;
                end
                ph_scan: begin
                    if (step == sp_send && push) begin
                        step <= sp_wait;
                    end else if (step == sp_wait && txn_done) begin
                        step <= sp_gap;
                    end else if (step == sp_gap) begin
                        wait_cnt <= wait_end ? '0 : wait_cnt + 1'b1;
                        if (wait_end) begin
                            step <= sp_send;
                            if (!ack_error) begin
                                found <= 1'b1;
                                found_addr <= lcd_i2c_pkg::probe_addrs[probe_idx];
                                phase <= ph_init;
                            end else if (probe_idx == probe_w'(lcd_i2c_pkg::probe_count - 1)) begin
                                no_device <= 1'b1;
                                phase <= ph_finish;
                            end else begin
                                probe_idx <= probe_idx + 1'b1;
                            end
                        end
                    end
                end
                ph_init: begin
                    if (step == sp_send && push) begin
                        nib_step <= nib_step + 1'b1;
                        if (nib_step == 2'd3) step <= sp_gap;  // Gap counts from last push
                    end else if (step == sp_gap) begin
                        wait_cnt <= wait_end ? '0 : wait_cnt + 1'b1;
                        if (wait_end) begin
                            step <= sp_send;
                            if (cmd_idx == cmd_w'(lcd_i2c_pkg::init_count - 1)) begin
                                phase <= ph_write;
                            end else begin
                                cmd_idx <= cmd_idx + 1'b1;
                            end
                        end
                    end
                end
                ph_write: begin
                    if (push) begin
                        nib_step <= nib_step + 1'b1;
                        if (nib_step == 2'd3) begin
                            if (byte_idx == byte_w'(write_bytes - 1)) begin
                                phase <= ph_finish;
                            end else begin
                                byte_idx <= byte_idx + 1'b1;
                            end
                        end
                    end
                end
                default: begin
                    // Last entry has left the bus
                    if (found && lcd_txn_cnt == txn_cnt_w'(lcd_txns)) done <= 1'b1;
                end
            endcase
        end
    end

endmodule

/* verilog/txn_fifo.sv */
// I2C write request FIFO
module txn_fifo #(
    parameter int fifo_depth = 4
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          push,
    input  logic [lcd_i2c_pkg::txn_w-1:0] push_data,
    input  logic                          pop,
    output logic [lcd_i2c_pkg::txn_w-1:0] pop_data,
    output logic                          full,
    output logic                          empty
);

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam logic [ptr_w:0] depth_c = (ptr_w + 1)'(fifo_depth);

    logic [lcd_i2c_pkg::txn_w-1:0] mem [fifo_depth];
    logic [ptr_w-1:0]              wr_ptr;
    logic [ptr_w-1:0]              rd_ptr;
    logic [ptr_w:0]                count;
    logic                          wr_en;
    logic                          rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;
    assign full = (count == depth_c);
    assign empty = (count == '0);
    assign pop_data = mem[rd_ptr];  // Head entry

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* common/lcd_i2c_pkg.sv */
// LCD over I2C shared definitions
package lcd_i2c_pkg;

    localparam int i2c_addr_w = 7;
    localparam int txn_w = i2c_addr_w + 8;  // Address over data byte

    localparam int probe_count = 3;
    localparam logic [i2c_addr_w-1:0] probe_addrs [probe_count] = '{
        7'h20, 7'h27, 7'h3F
    };

    localparam int init_count = 7;
    localparam logic [7:0] init_cmds [init_count] = '{
        8'h33, 8'h32, 8'h28, 8'h0C, 8'h06, 8'h01, 8'h80
    };

    localparam logic [7:0] line2_cmd = 8'hC0;  // Cursor to line two
    localparam int line_len = 16;

    // Both lines back to back, character 0 in the top byte
    localparam logic [8*2*line_len-1:0] message = {
        "Hello from FPGA!",
        "Addr: 0x??      "
    };

    // PCF8574 style pin mapping
    typedef struct packed {
        logic [3:0] nibble;
        logic       backlight;
        logic       en;
        logic       rw;
        logic       rs;
    } lcd_fields_t;

    typedef union packed {
        logic [7:0]  raw;
        lcd_fields_t lcd;
    } expander_byte_u;

    function automatic logic [7:0] hex_ascii(input logic [3:0] value);
        if (value < 4'd10) begin
            return 8'h30 + {4'h0, value};
        end
        return 8'h37 + {4'h0, value};  // 'A' minus ten
    endfunction

endpackage
